// File: src.f
design/lcd_timing_pkg.sv
design/lcd_bus_pkg.sv
design/lcd_init_seq.sv
design/lcd_write_engine.sv
design/lcd_pin_driver.sv
design/lcd_ctrl_top.sv
dv/lcd_ctrl_tb.sv

// File: Bender.yml
package:
  name: lcd_ctrl

dependencies: {}

sources:
  # packages first, then the design bottom up
  - files:
      - design/lcd_timing_pkg.sv
      - design/lcd_bus_pkg.sv
      - design/lcd_init_seq.sv
      - design/lcd_write_engine.sv
      - design/lcd_pin_driver.sv
      - design/lcd_ctrl_top.sv

  - target: test
    files:
      - dv/lcd_ctrl_tb.sv

// File: dv/lcd_ctrl_tb.sv
`timescale 1ns/1ps

module lcd_ctrl_tb;
	import lcd_timing_pkg::*;
	import lcd_bus_pkg::*;

	localparam int clk_per_us = 2;
	localparam int n_fixed    = 6;
	localparam int n_rows     = 10;  // fixed rows plus random ones
	localparam int pulse_cyc  = cmd_pulse_us * clk_per_us;
	localparam int cmds_cyc   = 4 * pulse_cyc
		+ (2 * short_wait_us + clear_wait_us + entry_wait_us) * clk_per_us;
	localparam int init_cyc   = powerup_us * clk_per_us + cmds_cyc;
	localparam int win_cyc    = write_win_us * clk_per_us;
	localparam int e_cyc      = (e_fall_us - e_rise_us) * clk_per_us;
	localparam int wd_cyc     = powerup_us * clk_per_us + cmds_cyc
		+ n_rows * (win_cyc + 4) + 500;

	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
		logic       while_busy;  // strobe while a window is running
	} row_t;

	typedef struct packed {
		logic        rs;
		logic        rw;
		logic [7:0]  data;
		logic [15:0] len;
	} pulse_t;

	logic       clk;
	logic       rst_n;
	lcd_mode_t  mode;
	logic       lcd_enable;
	lcd_req_t   lcd_bus;
	logic       e;
	logic       rs;
	logic       rw;
	logic [7:0] lcd_data;
	logic       busy;

	row_t   stim_tbl [n_rows];
	row_t   exp_wr[$];
	pulse_t init_seen[$];
	pulse_t wr_seen[$];
	int     busy_seen[$];
	pulse_t cur;
	int     e_len;
	int     busy_len;
	int     init_busy;
	logic   init_over;
	int     value_errs;
	int     other_errs;

	lcd_ctrl_top #(
		.clk_per_us(clk_per_us)
	) i_lcd_ctrl_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.mode      (mode),
		.lcd_enable(lcd_enable),
		.lcd_bus   (lcd_bus),
		.e         (e),
		.rs        (rs),
		.rw        (rw),
		.lcd_data  (lcd_data),
		.busy      (busy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_value(input string name, input int got, input int exp);
		value_errs++;
		$display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
	endtask

	task automatic report_other(input string msg);
		other_errs++;
		$display("%0t: %s", $time, msg);
	endtask

	// expected init byte, built from the HD44780 field positions
	function automatic logic [7:0] init_byte(input int idx, input lcd_mode_t m);
		case (idx)
			0:       init_byte = op_function_set | (8'(m.display_lines) << 3) | (8'(m.font) << 2);
			1:       init_byte = op_display_ctrl | (8'(m.display_on) << 2)
				| (8'(m.cursor) << 1) | 8'(m.blink);
			2:       init_byte = op_clear;
			default: init_byte = op_entry_mode | (8'(m.inc_dec) << 1) | 8'(m.shift);
		endcase
	endfunction

	// outputs are registered, so at the rising edge they still hold last cycle
	always @(posedge clk) begin
		if (rst_n) begin
			if (e) begin
				if (e_len == 0) begin
					cur.rs   = rs;
					cur.rw   = rw;
					cur.data = lcd_data;
				end else begin
					assert ({rs, rw, lcd_data} == {cur.rs, cur.rw, cur.data}) else
						report_value("rs/rw/lcd_data", {rs, rw, lcd_data},
							{cur.rs, cur.rw, cur.data});
				end
				e_len++;
			end else if (e_len != 0) begin
				cur.len = 16'(e_len);
				if (init_over) wr_seen.push_back(cur);
				else init_seen.push_back(cur);
				e_len = 0;
			end
			if (busy) begin
				busy_len++;
			end else begin
				if (busy_len != 0) begin
					if (init_over) busy_seen.push_back(busy_len);
					else init_busy = busy_len;
					busy_len = 0;
				end
				init_over = 1'b1;
				// idle bus between windows
				assert ({e, rs, rw, lcd_data} == 11'd0) else
					report_value("idle pins", {e, rs, rw, lcd_data}, 0);
			end
		end
	end

	task automatic wait_idle();
		while (busy !== 1'b0) @(negedge clk);
	endtask

	task automatic wait_busy();
		while (busy !== 1'b1) @(negedge clk);
	endtask

	task automatic apply_row(input row_t row);
		if (row.while_busy) wait_busy();
		else wait_idle();
		lcd_enable = 1'b1;
		lcd_bus.rs   = row.rs;
		lcd_bus.rw   = row.rw;
		lcd_bus.data = row.data;
		@(negedge clk);
		lcd_enable = 1'b0;
		if (!row.while_busy) begin
			exp_wr.push_back(row);
			wait_busy();  // busy lags the accept by one cycle
		end
	endtask

	task automatic check_init();
		assert (init_busy == init_cyc + 1) else
			report_value("busy init length", init_busy, init_cyc + 1);
		assert (init_seen.size() == 4) else
			report_other($sformatf("init gave %0d e pulses instead of 4", init_seen.size()));
		for (int i = 0; i < init_seen.size() && i < 4; i++) begin
			assert (init_seen[i].data == init_byte(i, mode)) else
				report_value($sformatf("init[%0d] lcd_data", i), init_seen[i].data,
					init_byte(i, mode));
			assert ({init_seen[i].rs, init_seen[i].rw} == 2'b00) else
				report_value($sformatf("init[%0d] rs/rw", i), {init_seen[i].rs, init_seen[i].rw}, 0);
			assert (init_seen[i].len == pulse_cyc) else
				report_value($sformatf("init[%0d] e length", i), init_seen[i].len, pulse_cyc);
		end
	endtask

	task automatic check_writes();
		assert (wr_seen.size() == exp_wr.size()) else
			report_other($sformatf("saw %0d write pulses, expected %0d",
				wr_seen.size(), exp_wr.size()));
		assert (busy_seen.size() == exp_wr.size()) else
			report_other($sformatf("saw %0d busy windows, expected %0d",
				busy_seen.size(), exp_wr.size()));
		for (int i = 0; i < wr_seen.size() && i < exp_wr.size(); i++) begin
			assert ({wr_seen[i].rs, wr_seen[i].rw} == {exp_wr[i].rs, exp_wr[i].rw}) else
				report_value($sformatf("wr[%0d] rs/rw", i), {wr_seen[i].rs, wr_seen[i].rw},
					{exp_wr[i].rs, exp_wr[i].rw});
			assert (wr_seen[i].data == exp_wr[i].data) else
				report_value($sformatf("wr[%0d] lcd_data", i), wr_seen[i].data, exp_wr[i].data);
			assert (wr_seen[i].len == e_cyc) else
				report_value($sformatf("wr[%0d] e length", i), wr_seen[i].len, e_cyc);
		end
		foreach (busy_seen[i]) begin
			assert (busy_seen[i] == win_cyc) else
				report_value($sformatf("wr[%0d] busy length", i), busy_seen[i], win_cyc);
		end
	endtask

	initial begin
		logic [31:0] rnd;
		rnd        = $urandom(19205);
		rst_n      = 1'b0;
		mode       = 7'b1011010;  // 2 lines, display and cursor on, increment
		lcd_enable = 1'b0;
		lcd_bus    = '0;
		e_len      = 0;
		busy_len   = 0;
		init_busy  = 0;
		init_over  = 1'b0;
		value_errs = 0;
		other_errs = 0;
		stim_tbl[0] = '{rs: 1'b1, rw: 1'b0, data: 8'h48, while_busy: 1'b0};
		stim_tbl[1] = '{rs: 1'b1, rw: 1'b0, data: 8'h69, while_busy: 1'b1};
		stim_tbl[2] = '{rs: 1'b0, rw: 1'b0, data: 8'h80, while_busy: 1'b0};
		stim_tbl[3] = '{rs: 1'b1, rw: 1'b1, data: 8'hA5, while_busy: 1'b0};
		stim_tbl[4] = '{rs: 1'b0, rw: 1'b1, data: 8'h5A, while_busy: 1'b1};
		stim_tbl[5] = '{rs: 1'b1, rw: 1'b0, data: 8'hFF, while_busy: 1'b0};
		for (int i = n_fixed; i < n_rows; i++) begin
			rnd = $urandom;
			stim_tbl[i] = '{rs: rnd[8], rw: rnd[9], data: rnd[7:0], while_busy: rnd[10]};
		end
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		// strobes during power-up and the init commands must be dropped
		// the last one falls late in the entry mode wait
		repeat (5) begin
			repeat (370) @(negedge clk);
			lcd_enable   = 1'b1;
			lcd_bus.rs   = 1'b1;
			lcd_bus.data = 8'hEE;
			@(negedge clk);
			lcd_enable = 1'b0;
		end
		wait_idle();
		for (int i = 0; i < n_rows; i++) apply_row(stim_tbl[i]);
		wait_idle();
		repeat (20) @(negedge clk);
		check_init();
		check_writes();
		$display("errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(wd_cyc * 20);
		$display("watchdog expired after %0d cycles, DUT did not go idle", wd_cyc);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: design/lcd_ctrl_top.sv
`timescale 1ns/1ps

module lcd_ctrl_top
	import lcd_bus_pkg::*;
#(
	parameter int clk_per_us = 15
) (
	input  logic       clk,
	input  logic       rst_n,
	input  lcd_mode_t  mode,
	input  logic       lcd_enable,
	input  lcd_req_t   lcd_bus,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	lcd_pins_t init_pins;
	lcd_pins_t wr_pins;
	lcd_pins_t pins;
	logic      init_done;
	logic      wr_active;

	lcd_init_seq #(
		.clk_per_us(clk_per_us)
	) i_lcd_init_seq (
		.clk      (clk),
		.rst_n    (rst_n),
		.mode     (mode),
		.init_pins(init_pins),
		.init_done(init_done)
	);

	lcd_write_engine #(
		.clk_per_us(clk_per_us)
	) i_lcd_write_engine (
		.clk       (clk),
		.rst_n     (rst_n),
		.lcd_enable(lcd_enable),
		.lcd_bus   (lcd_bus),
		.init_done (init_done),
		.wr_pins   (wr_pins),
		.wr_active (wr_active)
	);

	lcd_pin_driver i_lcd_pin_driver (
		.clk      (clk),
		.rst_n    (rst_n),
		.init_pins(init_pins),
		.wr_pins  (wr_pins),
		.init_done(init_done),
		.wr_active(wr_active),
		.pins     (pins),
		.busy     (busy)
	);

	// bundle out to the connector pins
	assign e        = pins.e;
	assign rs       = pins.rs;
	assign rw       = pins.rw;
	assign lcd_data = pins.data;

endmodule

// File: design/lcd_pin_driver.sv
`timescale 1ns/1ps

module lcd_pin_driver
	import lcd_bus_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  lcd_pins_t init_pins,
	input  lcd_pins_t wr_pins,
	input  logic      init_done,
	input  logic      wr_active,
	output lcd_pins_t pins,
	output logic      busy
);

	lcd_pins_t pins_nxt;
	logic      busy_nxt;

	// sequencer owns the pins until init is done, then the write engine
	always_comb begin
		if (!init_done) begin
			pins_nxt = init_pins;
		end else if (wr_active) begin
			pins_nxt = wr_pins;
		end else begin
			pins_nxt = '0;  // idle bus between windows
		end
	end

	assign busy_nxt = !init_done || wr_active;

	// one register stage on every pin, so no glitch at a source change
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pins <= '0;
			busy <= 1'b1;  // busy through reset and init
		end else begin
			pins <= pins_nxt;
			busy <= busy_nxt;
		end
	end

endmodule

// File: design/lcd_write_engine.sv
`timescale 1ns/1ps

module lcd_write_engine
	import lcd_timing_pkg::*;
	import lcd_bus_pkg::*;
#(
	parameter int clk_per_us = 15
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      lcd_enable,
	input  lcd_req_t  lcd_bus,
	input  logic      init_done,
	output lcd_pins_t wr_pins,
	output logic      wr_active
);

	localparam int win_cyc = write_win_us * clk_per_us;
	localparam int cnt_w   = $clog2(win_cyc + 1);

	typedef logic [cnt_w-1:0] cnt_t;

	localparam cnt_t win_last = cnt_t'(win_cyc - 1);
	localparam cnt_t e_rise   = cnt_t'(e_rise_us * clk_per_us);
	localparam cnt_t e_fall   = cnt_t'(e_fall_us * clk_per_us);

	lcd_req_t req_q;   // request held for the whole window
	cnt_t     cnt;     // 0 on the first active cycle
	logic     accept;
	logic     e_win;

	// enables seen while a window runs are dropped, not queued
	assign accept = lcd_enable && init_done && !wr_active;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_active <= 1'b0;
			cnt       <= '0;
		end else if (accept) begin
			wr_active <= 1'b1;
			cnt       <= '0;
		end else if (wr_active) begin
			if (cnt == win_last) begin
				wr_active <= 1'b0;  // window over
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= lcd_bus;
		end
	end

	// e high in [e_rise, e_fall) of the window
	assign e_win = (cnt >= e_rise) && (cnt < e_fall);

	assign wr_pins.e    = wr_active && e_win;
	assign wr_pins.rs   = req_q.rs;
	assign wr_pins.rw   = req_q.rw;
	assign wr_pins.data = req_q.data;

endmodule

// File: design/lcd_init_seq.sv
`timescale 1ns/1ps

module lcd_init_seq
	import lcd_timing_pkg::*;
	import lcd_bus_pkg::*;
#(
	parameter int clk_per_us = 15
) (
	input  logic      clk,
	input  logic      rst_n,
	input  lcd_mode_t mode,
	output lcd_pins_t init_pins,
	output logic      init_done
);

	// power-up is the longest interval, so it sizes the counter
	localparam int cnt_w = $clog2(powerup_us * clk_per_us + 1);

	typedef logic [cnt_w-1:0] cnt_t;

	localparam cnt_t powerup_last = cnt_t'(powerup_us * clk_per_us - 1);
	localparam cnt_t pulse_last   = cnt_t'(cmd_pulse_us * clk_per_us - 1);

	typedef enum logic [1:0] {
		st_powerup,
		st_cmd,
		st_wait,
		st_done
	} step_t;

	step_t      step;
	logic [1:0] cmd_idx;  // 0 function set .. 3 entry mode
	cnt_t       cnt;

	// last count of the wait that follows command idx
	function automatic cnt_t wait_last(input logic [1:0] idx);
		case (idx)
			2'd0, 2'd1: wait_last = cnt_t'(short_wait_us * clk_per_us - 1);
			2'd2:       wait_last = cnt_t'(clear_wait_us * clk_per_us - 1);
			default:    wait_last = cnt_t'(entry_wait_us * clk_per_us - 1);
		endcase
	endfunction

	// instruction byte for command idx with the current mode fields
	function automatic logic [7:0] cmd_byte(input logic [1:0] idx, input lcd_mode_t m);
		case (idx)
			2'd0:    cmd_byte = op_function_set | {4'b0, m.display_lines, m.font, 2'b0};
			2'd1:    cmd_byte = op_display_ctrl | {5'b0, m.display_on, m.cursor, m.blink};
			2'd2:    cmd_byte = op_clear;
			default: cmd_byte = op_entry_mode | {6'b0, m.inc_dec, m.shift};
		endcase
	endfunction

	// pin bundle that starts a command pulse
	function automatic lcd_pins_t cmd_pins(input logic [1:0] idx, input lcd_mode_t m);
		cmd_pins      = '0;
		cmd_pins.e    = 1'b1;
		cmd_pins.data = cmd_byte(idx, m);  // rs and rw stay low for instructions
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			step      <= st_powerup;
			cmd_idx   <= '0;
			cnt       <= '0;
			init_pins <= '0;
			init_done <= 1'b0;
		end else begin
			case (step)
				st_powerup: begin
					if (cnt == powerup_last) begin
						cnt       <= '0;
						step      <= st_cmd;
						init_pins <= cmd_pins(cmd_idx, mode);  // mode sampled here
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_cmd: begin
					if (cnt == pulse_last) begin
						cnt       <= '0;
						step      <= st_wait;
						init_pins <= '0;  // e and data low during the wait
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_wait: begin
					if (cnt == wait_last(cmd_idx)) begin
						cnt <= '0;
						if (cmd_idx == 2'd3) begin
							step      <= st_done;
							init_done <= 1'b1;
						end else begin
							cmd_idx   <= cmd_idx + 2'd1;
							step      <= st_cmd;
							init_pins <= cmd_pins(cmd_idx + 2'd1, mode);
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					init_done <= 1'b1;  // held until the next reset
				end
			endcase
		end
	end

endmodule

// File: design/lcd_bus_pkg.sv
package lcd_bus_pkg;

	// mode word, msb first; same bit order as the external 7-bit input
	typedef struct packed {
		logic display_lines;  // N, 1 = two lines
		logic font;           // F, 1 = 5x10 dots
		logic display_on;     // D
		logic cursor;         // C
		logic blink;          // B
		logic inc_dec;        // I/D, 1 = increment
		logic shift;          // S, shift display on write
	} lcd_mode_t;

	// everything that goes out to the LCD connector
	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	// one bus write, same layout as lcd_bus[9:0]
	typedef struct packed {
		logic       rs;    // bit 9
		logic       rw;    // bit 8
		logic [7:0] data;  // bits 7:0
	} lcd_req_t;

	// instruction base codes, mode fields are OR-ed into the low bits
	localparam logic [7:0] op_function_set = 8'b0011_0000;  // 8-bit bus, N at 3, F at 2
	localparam logic [7:0] op_display_ctrl = 8'b0000_1000;  // D at 2, C at 1, B at 0
	localparam logic [7:0] op_clear        = 8'b0000_0001;
	localparam logic [7:0] op_entry_mode   = 8'b0000_0100;  // I/D at 1, S at 0

endpackage

// File: design/lcd_timing_pkg.sv
package lcd_timing_pkg;

	// all values are in microseconds
	// modules scale them by their clk_per_us parameter

	// power-up settling time of the LCD controller
	localparam int powerup_us    = 500;

	// e high time for each initialisation command
	localparam int cmd_pulse_us  = 10;

	// waits that follow each initialisation command
	localparam int short_wait_us = 50;   // after function set and display control
	localparam int clear_wait_us = 200;  // clear is the slowest instruction
	localparam int entry_wait_us = 100;  // after entry mode set

	// write window; e rises and falls at fixed offsets inside it
	localparam int write_win_us  = 50;   // whole window, busy for this long
	localparam int e_rise_us     = 1;    // setup of rs, rw, data before e
	localparam int e_fall_us     = 14;   // e high until here

endpackage
